//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f vlog.f --top-module sss_detector_tb -o sss_sim

./obj_dir/sss_sim | tee sim.log

if grep -q "Some tests failed" sim.log; then
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    exit 1
fi

//--- tb/sss_cases.txt
# name n_id_2 n_id_1 flip_count then flip_count flipped bit positions
# the testbench builds each 127 bit sequence from n_id_2 and n_id_1
clean_nid2_0_c57 0 57 0
clean_nid2_1_c190 1 190 0
clean_nid2_2_c301 2 301 0
edge_c0 0 0 0
edge_c111 1 111 0
edge_c112 2 112 0
edge_c223 0 223 0
edge_c224 1 224 0
edge_c335 2 335 0
flip1_c42 1 42 1 5
flip4_c150 2 150 4 0 31 64 126
flip7_c335 1 335 7 2 9 40 41 77 100 118
flip10_c260 0 260 10 3 17 29 44 58 71 85 99 110 123
flip10_c0 2 0 10 1 12 23 34 45 56 67 78 89 120

//--- tb/sss_detector_tb.sv
`timescale 1ns/1ps

module sss_detector_tb import sss_pkg::*; ();

    localparam int MAX_CASES = 64;
    localparam int MAX_FLIPS = 10;
    // search plus bit transfer per case with margin
    localparam int CASE_CYCLES = 44000;

    logic    clk;
    logic    reset_n;
    logic    sss_bit;
    logic    sss_valid;
    n_id_2_t n_id_2;
    logic    n_id_2_valid;
    n_id_1_t n_id_1;
    n_id_t   n_id;
    corr_t   corr_peak;
    logic    n_id_valid;

    // case table filled from tb/sss_cases.txt
    string   case_name     [MAX_CASES];
    n_id_2_t case_n_id_2   [MAX_CASES];
    n_id_1_t case_n_id_1   [MAX_CASES];
    int      case_flips    [MAX_CASES];
    int      case_flip_pos [MAX_CASES][MAX_FLIPS];
    int      num_cases;

    // reference m-sequences x0 and x1
    logic    x0_ref [SSS_LEN];
    logic    x1_ref [SSS_LEN];

    int      seed;
    int      cycle_count = 0;
    int      cycle_limit = 0;
    int      pulse_count = 0;
    int      pass_count;
    int      fail_count;
    logic    case_ok;
    logic    setup_error;

    sss_detector_top i_dut (
        .clk_i          (clk),
        .reset_ni       (reset_n),
        .sss_bit_i      (sss_bit),
        .sss_valid_i    (sss_valid),
        .n_id_2_i       (n_id_2),
        .n_id_2_valid_i (n_id_2_valid),
        .n_id_1_o       (n_id_1),
        .n_id_o         (n_id),
        .corr_peak_o    (corr_peak),
        .n_id_valid_o   (n_id_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // counts every result pulse including stray ones
    always @(negedge clk) begin
        if (n_id_valid) begin
            pulse_count <= pulse_count + 1;
        end
    end

    // x0 uses x(i+7) = x(i+4) xor x(i) and x1 uses x(i+7) = x(i+1) xor x(i)
    // both start from 0000001 with x(0) = 1
    task automatic build_ref_sequences();
        int i;
        for (i = 0; i < LFSR_LEN; i++) begin
            x0_ref[i] = (i == 0);
            x1_ref[i] = (i == 0);
        end
        for (i = 0; i < SSS_LEN - LFSR_LEN; i++) begin
            x0_ref[i+7] = x0_ref[i+4] ^ x0_ref[i];
            x1_ref[i+7] = x1_ref[i+1] ^ x1_ref[i];
        end
    endtask

    // expected bit n is 1 when x0[(n+m0) mod 127] equals x1[(n+m1) mod 127]
    function automatic sss_bits_t sss_sequence(input n_id_2_t n2, input n_id_1_t n1);
        sss_bits_t bits;
        int        m0;
        int        m1;
        int        n;
        m0 = 15 * (int'(n1) / 112) + 5 * int'(n2);
        m1 = int'(n1) % 112;
        for (n = 0; n < SSS_LEN; n++) begin
            bits[n] = (x0_ref[(n + m0) % SSS_LEN] == x1_ref[(n + m1) % SSS_LEN]);
        end
        return bits;
    endfunction

    task automatic read_cases();
        int    fd;
        int    rc;
        int    n2;
        int    n1;
        int    k;
        int    pos;
        int    j;
        string tok;
        string line;
        num_cases = 0;
        fd = $fopen("tb/sss_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tb/sss_cases.txt");
        end else begin
            rc = $fscanf(fd, "%s", tok);
            while (rc == 1 && num_cases < MAX_CASES) begin
                if (tok.getc(0) == "#") begin
                    // column description line
                    rc = $fgets(line, fd);
                end else begin
                    rc = $fscanf(fd, "%d %d %d", n2, n1, k);
                    if (rc != 3) begin
                        $display("case %s has a malformed line", tok);
                        setup_error = 1'b1;
                        k = 0;
                    end
                    if (k > MAX_FLIPS) begin
                        $display("case %s lists too many flipped bits", tok);
                        setup_error = 1'b1;
                        k = MAX_FLIPS;
                    end
                    case_name[num_cases]   = tok;
                    case_n_id_2[num_cases] = n_id_2_t'(n2);
                    case_n_id_1[num_cases] = n_id_1_t'(n1);
                    case_flips[num_cases]  = k;
                    for (j = 0; j < k; j++) begin
                        rc = $fscanf(fd, "%d", pos);
                        case_flip_pos[num_cases][j] = pos;
                    end
                    num_cases++;
                end
                rc = $fscanf(fd, "%s", tok);
            end
            $fclose(fd);
        end
    endtask

    task automatic check_n_id_1(input string name, input n_id_1_t exp, input n_id_1_t act);
        if (act !== exp) begin
            $display("mismatch %s n_id_1 expected %0d actual %0d", name, exp, act);
            case_ok = 1'b0;
        end
    endtask

    task automatic check_n_id(input string name, input n_id_t exp, input n_id_t act);
        if (act !== exp) begin
            $display("mismatch %s n_id expected %0d actual %0d", name, exp, act);
            case_ok = 1'b0;
        end
    endtask

    task automatic check_peak(input string name, input corr_t exp, input corr_t act);
        if (act !== exp) begin
            $display("mismatch %s peak expected %0d actual %0d", name, exp, act);
            case_ok = 1'b0;
        end
    endtask

    task automatic report_case(input string name);
        if (case_ok) begin
            pass_count++;
            $display("%s ok", name);
        end else begin
            fail_count++;
            $display("%s FAILED", name);
        end
    endtask

    // outputs stay at zero while the sequence store fills and no search has run
    task automatic check_after_reset();
        int cyc;
        case_ok = 1'b1;
        cyc = 0;
        while (cyc < 200 && case_ok) begin
            @(negedge clk);
            if (n_id_valid !== 1'b0) begin
                $display("after_reset: n_id_valid_o high before any search");
                case_ok = 1'b0;
            end
            check_n_id_1("after_reset", '0, n_id_1);
            check_n_id("after_reset", '0, n_id);
            check_peak("after_reset", '0, corr_peak);
            cyc++;
        end
        report_case("after_reset");
    endtask

    task automatic run_case(input int idx);
        sss_bits_t   bits;
        n_id_2_t     other_n2;
        logic [31:0] junk;
        int          gap;
        int          n;
        logic        got;
        bits = sss_sequence(case_n_id_2[idx], case_n_id_1[idx]);
        for (n = 0; n < case_flips[idx]; n++) begin
            bits[case_flip_pos[idx][n]] = ~bits[case_flip_pos[idx][n]];
        end
        case_ok = 1'b1;
        // n_id_2 from the pss stage comes first
        @(negedge clk);
        n_id_2       = case_n_id_2[idx];
        n_id_2_valid = 1'b1;
        @(negedge clk);
        n_id_2_valid = 0;
        // sss bits with random idle gaps
        for (n = 0; n < SSS_LEN; n++) begin
            gap = $unsigned($random(seed)) % 4;
            repeat (gap) @(negedge clk);
            sss_bit   = bits[n];
            sss_valid = 1'b1;
            @(negedge clk);
            sss_valid = 1'b0;
        end
        // junk bits while the search runs are dropped by the capture
        for (n = 0; n < 16; n++) begin
            junk      = $random(seed);
            sss_bit   = junk[0];
            sss_valid = 1'b1;
            @(negedge clk);
        end
        sss_valid    = 1'b0;
        // a different n_id_2 strobe that the full buffer ignores
        other_n2     = n_id_2_t'((int'(case_n_id_2[idx]) + 1) % 3);
        n_id_2       = other_n2;
        n_id_2_valid = 1'b1;
        @(negedge clk);
        n_id_2_valid = 1'b0;
        // watchdog ends the run if the result never comes
        got = 1'b0;
        while (!got) begin
            @(negedge clk);
            got = n_id_valid;
        end
        check_n_id_1(case_name[idx], case_n_id_1[idx], n_id_1);
        check_n_id(case_name[idx],
                   n_id_t'(3 * int'(case_n_id_1[idx]) + int'(case_n_id_2[idx])), n_id);
        check_peak(case_name[idx], corr_t'(SSS_LEN - case_flips[idx]), corr_peak);
        // result valid is a single cycle pulse
        @(negedge clk);
        if (n_id_valid !== 1'b0) begin
            $display("%s: n_id_valid_o stayed high for more than one cycle", case_name[idx]);
            case_ok = 1'b0;
        end
        report_case(case_name[idx]);
    endtask

    initial begin
        int i;
        reset_n      = 1'b0;
        sss_bit      = 1'b0;
        sss_valid    = 1'b0;
        n_id_2       = '0;
        n_id_2_valid = 1'b0;
        seed         = 32'h925b;
        pass_count   = 0;
        fail_count   = 0;
        setup_error  = 1'b0;
        build_ref_sequences();
        read_cases();
        if (num_cases == 0) begin
            $display("no test cases could be read");
            setup_error = 1'b1;
        end else begin
            cycle_limit = num_cases * CASE_CYCLES + 2000;
            repeat (16) @(negedge clk);
            reset_n = 1'b1;
            check_after_reset();
            for (i = 0; i < num_cases; i++) begin
                run_case(i);
            end
            @(negedge clk);
            if (pulse_count != num_cases) begin
                $display("saw %0d result pulses for %0d cases", pulse_count, num_cases);
                fail_count++;
            end
        end
        $display("passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0 && !setup_error) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog with the limit set once the cases are known
    initial begin
        wait (cycle_limit > 0);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
        end
        $display("timeout waiting for result");
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- verilog/mseq_lfsr.sv
`timescale 1ns/1ps

// fibonacci lfsr, one m-sequence bit per cycle
// reg[0] is the oldest bit x(i), reg[k] holds x(i+k)
module mseq_lfsr #(
    parameter int unsigned        LEN  = 7,
    parameter logic [LEN-1:0]     TAPS = 'h11,
    parameter logic [LEN-1:0]     SEED = 'h01
) (
    input  logic clk_i,
    input  logic reset_ni,
    output logic bit_o,
    output logic valid_o
);

    logic [LEN-1:0] lfsr_q;
    logic           valid_q;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            lfsr_q  <= SEED;
            valid_q <= 1'b0;
        end else begin
            valid_q <= 1'b1;
            // hold the seed for the first valid cycle so x(0) is seen
            if (valid_q) begin
                lfsr_q <= {^(lfsr_q & TAPS), lfsr_q[LEN-1:1]};
            end
        end
    end

    assign bit_o   = lfsr_q[0];
    assign valid_o = valid_q;

endmodule

//--- verilog/mseq_store.sv
`timescale 1ns/1ps

// generates x0 and x1 once after reset and keeps them for random reads
module mseq_store import sss_pkg::*; (
    input  logic   clk_i,
    input  logic   reset_ni,
    mseq_if.store  mseq
);

    logic x0_bit;
    logic x0_valid;
    logic x1_bit;
    logic x1_valid;

    logic [SSS_LEN-1:0] x0_mem;
    logic [SSS_LEN-1:0] x1_mem;

    gen_state_t state_q;
    seq_idx_t   wr_idx_q;

    mseq_lfsr #(
        .LEN  (LFSR_LEN),
        .TAPS (X0_TAPS),
        .SEED (LFSR_LEN'(1))
    ) i_lfsr_x0 (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .bit_o    (x0_bit),
        .valid_o  (x0_valid)
    );

    mseq_lfsr #(
        .LEN  (LFSR_LEN),
        .TAPS (X1_TAPS),
        .SEED (LFSR_LEN'(1))
    ) i_lfsr_x1 (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .bit_o    (x1_bit),
        .valid_o  (x1_valid)
    );

    // write one bit of each sequence per cycle, 127 cycles in total
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q  <= GEN_RUN;
            wr_idx_q <= '0;
        end else if (state_q == GEN_RUN && x0_valid && x1_valid) begin
            if (wr_idx_q == seq_idx_t'(SSS_LEN - 1)) begin
                state_q <= GEN_DONE;
            end
            wr_idx_q <= wr_idx_q + 1'b1;
        end
    end

    // sequence storage, contents only meaningful once ready
    always_ff @(posedge clk_i) begin
        if (state_q == GEN_RUN && x0_valid && x1_valid) begin
            x0_mem[wr_idx_q] <= x0_bit;
            x1_mem[wr_idx_q] <= x1_bit;
        end
    end

    assign mseq.ready = (state_q == GEN_DONE);
    // combinational read, used by the correlator in the same cycle
    assign mseq.bit0  = x0_mem[mseq.addr0];
    assign mseq.bit1  = x1_mem[mseq.addr1];

endmodule

//--- verilog/sss_capture.sv
`timescale 1ns/1ps

// fills the 127 bit sss buffer and holds it until the search releases it
module sss_capture import sss_pkg::*; (
    input  logic          clk_i,
    input  logic          reset_ni,
    input  logic          sss_bit_i,
    input  logic          sss_valid_i,
    input  n_id_2_t       n_id_2_i,
    input  logic          n_id_2_valid_i,
    sss_buf_if.capture    sss_buf
);

    logic      full_q;
    seq_idx_t  wr_idx_q;
    sss_bits_t bits_q;
    n_id_2_t   n_id_2_q;

    // control: write pointer and full flag
    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            full_q   <= 1'b0;
            wr_idx_q <= '0;
        end else if (sss_buf.buf_release) begin
            // search done, arm for the next block
            full_q   <= 1'b0;
            wr_idx_q <= '0;
        end else if (sss_valid_i && !full_q) begin
            if (wr_idx_q == seq_idx_t'(SSS_LEN - 1)) begin
                full_q   <= 1'b1;
                wr_idx_q <= '0;
            end else begin
                wr_idx_q <= wr_idx_q + 1'b1;
            end
        end
    end

    // payload, frozen while full
    always_ff @(posedge clk_i) begin
        if (sss_valid_i && !full_q) begin
            bits_q[wr_idx_q] <= sss_bit_i;
        end
        // last strobe before full wins
        if (n_id_2_valid_i && !full_q) begin
            n_id_2_q <= n_id_2_i;
        end
    end

    assign sss_buf.full   = full_q;
    assign sss_buf.bits   = bits_q;
    assign sss_buf.n_id_2 = n_id_2_q;

endmodule

//--- verilog/sss_correlator.sv
`timescale 1ns/1ps

// searches all 336 n_id_1 candidates against the captured block
// each candidate: 127 compare cycles, then one decide cycle
module sss_correlator import sss_pkg::*; (
    input  logic        clk_i,
    input  logic        reset_ni,
    sss_buf_if.search   sss_buf,
    mseq_if.reader      mseq,
    output n_id_1_t     n_id_1_o,
    output n_id_t       n_id_o,
    output corr_t       corr_peak_o,
    output logic        n_id_valid_o
);

    corr_state_t state_q;
    n_id_1_t     cand_q;
    // m1 of the current candidate, 0..111
    seq_idx_t    shift_q;
    // m0 of the current group
    seq_idx_t    m0_base_q;
    // read pointers into x0 and x1, wrap 126 -> 0
    seq_idx_t    ptr0_q;
    seq_idx_t    ptr1_q;
    seq_idx_t    bit_idx_q;
    corr_t       acc_q;
    corr_t       peak_q;
    n_id_1_t     best_q;
    logic        release_q;

    logic        better;
    n_id_1_t     best_nxt;
    corr_t       peak_nxt;
    logic        match;

    // 5 * n_id_2 without a multiplier
    function automatic seq_idx_t m0_start(input n_id_2_t n_id_2);
        case (n_id_2)
            2'd1:    return seq_idx_t'(M0_NID2_STEP);
            2'd2:    return seq_idx_t'(2 * M0_NID2_STEP);
            default: return '0;
        endcase
    endfunction

    assign mseq.addr0 = ptr0_q;
    assign mseq.addr1 = ptr1_q;

    // expected bit is 1 when x0 and x1 agree
    assign match = (sss_buf.bits[bit_idx_q] == ~(mseq.bit0 ^ mseq.bit1));

    // only a strictly greater count moves the best, lowest candidate wins ties
    always_comb begin
        better   = (acc_q > peak_q);
        best_nxt = better ? cand_q : best_q;
        peak_nxt = better ? acc_q : peak_q;
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state_q      <= CORR_IDLE;
            cand_q       <= '0;
            shift_q      <= '0;
            m0_base_q    <= '0;
            ptr0_q       <= '0;
            ptr1_q       <= '0;
            bit_idx_q    <= '0;
            acc_q        <= '0;
            peak_q       <= '0;
            best_q       <= '0;
            release_q    <= 1'b0;
            n_id_1_o     <= '0;
            n_id_o       <= '0;
            corr_peak_o  <= '0;
            n_id_valid_o <= 1'b0;
        end else begin
            release_q    <= 1'b0;
            n_id_valid_o <= 1'b0;
            case (state_q)
                CORR_IDLE: begin
                    // full is still high in the release cycle, skip it
                    if (sss_buf.full && mseq.ready && !release_q) begin
                        state_q   <= CORR_COMPARE;
                        cand_q    <= '0;
                        shift_q   <= '0;
                        m0_base_q <= m0_start(sss_buf.n_id_2);
                        ptr0_q    <= m0_start(sss_buf.n_id_2);
                        ptr1_q    <= '0;
                        bit_idx_q <= '0;
                        acc_q     <= '0;
                        peak_q    <= '0;
                        best_q    <= '0;
                    end
                end
                CORR_COMPARE: begin
                    if (match) begin
                        acc_q <= acc_q + 1'b1;
                    end
                    ptr0_q <= (ptr0_q == seq_idx_t'(SSS_LEN - 1)) ? '0 : ptr0_q + 1'b1;
                    ptr1_q <= (ptr1_q == seq_idx_t'(SSS_LEN - 1)) ? '0 : ptr1_q + 1'b1;
                    if (bit_idx_q == seq_idx_t'(SSS_LEN - 1)) begin
                        state_q <= CORR_DECIDE;
                    end
                    bit_idx_q <= bit_idx_q + 1'b1;
                end
                CORR_DECIDE: begin
                    best_q <= best_nxt;
                    peak_q <= peak_nxt;
                    if (cand_q == n_id_1_t'(N_ID_1_MAX)) begin
                        // search done, publish and free the buffer
                        state_q      <= CORR_IDLE;
                        n_id_1_o     <= best_nxt;
                        n_id_o       <= n_id_t'({best_nxt, 1'b0}) + n_id_t'(best_nxt)
                                        + n_id_t'(sss_buf.n_id_2);
                        corr_peak_o  <= peak_nxt;
                        n_id_valid_o <= 1'b1;
                        release_q    <= 1'b1;
                    end else begin
                        state_q   <= CORR_COMPARE;
                        cand_q    <= cand_q + 1'b1;
                        bit_idx_q <= '0;
                        acc_q     <= '0;
                        if (shift_q == seq_idx_t'(SHIFT_PER_GROUP - 1)) begin
                            // next group: m1 back to 0, m0 up by 15
                            shift_q   <= '0;
                            m0_base_q <= m0_base_q + seq_idx_t'(M0_GROUP_STEP);
                            ptr0_q    <= m0_base_q + seq_idx_t'(M0_GROUP_STEP);
                            ptr1_q    <= '0;
                        end else begin
                            shift_q <= shift_q + 1'b1;
                            ptr0_q  <= m0_base_q;
                            ptr1_q  <= shift_q + 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= CORR_IDLE;
                end
            endcase
        end
    end

    assign sss_buf.buf_release = release_q;

endmodule

//--- verilog/sss_detector_top.sv
`timescale 1ns/1ps

// sss detector: capture, m-sequence store and candidate search
module sss_detector_top import sss_pkg::*; (
    input  logic    clk_i,
    input  logic    reset_ni,
    input  logic    sss_bit_i,
    input  logic    sss_valid_i,
    input  n_id_2_t n_id_2_i,
    input  logic    n_id_2_valid_i,
    output n_id_1_t n_id_1_o,
    output n_id_t   n_id_o,
    output corr_t   corr_peak_o,
    output logic    n_id_valid_o
);

    // sequence reads between store and correlator
    mseq_if    mseq_bus ();
    // captured block between capture and correlator
    sss_buf_if sss_buf_bus ();

    sss_capture i_capture (
        .clk_i          (clk_i),
        .reset_ni       (reset_ni),
        .sss_bit_i      (sss_bit_i),
        .sss_valid_i    (sss_valid_i),
        .n_id_2_i       (n_id_2_i),
        .n_id_2_valid_i (n_id_2_valid_i),
        .sss_buf        (sss_buf_bus)
    );

    mseq_store i_mseq (
        .clk_i    (clk_i),
        .reset_ni (reset_ni),
        .mseq     (mseq_bus)
    );

    sss_correlator i_corr (
        .clk_i        (clk_i),
        .reset_ni     (reset_ni),
        .sss_buf      (sss_buf_bus),
        .mseq         (mseq_bus),
        .n_id_1_o     (n_id_1_o),
        .n_id_o       (n_id_o),
        .corr_peak_o  (corr_peak_o),
        .n_id_valid_o (n_id_valid_o)
    );

endmodule

//--- verilog/sss_if.sv
`timescale 1ns/1ps

// read port into the stored m-sequences
interface mseq_if import sss_pkg::*; ();
    // both sequences written
    logic     ready;
    seq_idx_t addr0;
    seq_idx_t addr1;
    // x0[addr0] and x1[addr1], same cycle
    logic     bit0;
    logic     bit1;

    modport store (output ready, bit0, bit1, input addr0, addr1);
    modport reader (input ready, bit0, bit1, output addr0, addr1);
endinterface

// captured sss block handed from capture to search
interface sss_buf_if import sss_pkg::*; ();
    logic      full;
    sss_bits_t bits;
    n_id_2_t   n_id_2;
    // one cycle pulse, search finished with the buffer
    logic      buf_release;

    modport capture (output full, bits, n_id_2, input buf_release);
    modport search (input full, bits, n_id_2, output buf_release);
endinterface

//--- verilog/sss_pkg.sv
package sss_pkg;

    // sss sequence length and candidate search range
    localparam int SSS_LEN         = 127;
    localparam int N_ID_1_MAX      = 335;
    // m1 runs 0..111 inside one group of n_id_1 values
    localparam int SHIFT_PER_GROUP = 112;
    localparam int M0_GROUP_STEP   = 15;
    localparam int M0_NID2_STEP    = 5;

    // m-sequence generators, both 7 bit
    localparam int LFSR_LEN = 7;
    // x0: x(i+7) = x(i+4) xor x(i)
    localparam logic [LFSR_LEN-1:0] X0_TAPS = 7'h11;
    // x1: x(i+7) = x(i+1) xor x(i)
    localparam logic [LFSR_LEN-1:0] X1_TAPS = 7'h03;

    // received hard bits, index n holds bit n of the sequence
    typedef logic [SSS_LEN-1:0] sss_bits_t;
    // position inside a 127 bit sequence
    typedef logic [6:0] seq_idx_t;
    // match count, up to 127
    typedef logic [6:0] corr_t;
    typedef logic [8:0] n_id_1_t;
    typedef logic [1:0] n_id_2_t;
    // full cell id up to 1007
    typedef logic [9:0] n_id_t;

    typedef enum logic [1:0] {
        CORR_IDLE,
        CORR_COMPARE,
        CORR_DECIDE
    } corr_state_t;

    typedef enum logic {
        GEN_RUN,
        GEN_DONE
    } gen_state_t;

endpackage

//--- vlog.f
verilog/sss_pkg.sv
verilog/sss_if.sv
verilog/mseq_lfsr.sv
verilog/mseq_store.sv
verilog/sss_capture.sv
verilog/sss_correlator.sv
verilog/sss_detector_top.sv
tb/sss_detector_tb.sv
